//--- include/axil_noc_defines.svh
// axi-lite to noc bridge widths, queue depth, flit field positions and message codes
`ifndef AXIL_NOC_DEFINES_SVH
`define AXIL_NOC_DEFINES_SVH

`define AXIL_ADDR_W     40
`define AXIL_DATA_W     64
`define AXIL_STRB_W     8
`define NOC_DATA_W      64
`define REQ_FIFO_DEPTH  4

// field widths shared by header 1 and header 3
`define CHIPID_W        14
`define COORD_W         8
`define FBITS_W         4
`define MSG_LEN_W       8
`define MSG_TYPE_W      8
`define MSHRID_W        8
`define OPTIONS_W       6

// header 1, destination and message info
`define MSG_DST_CHIPID  63:50
`define MSG_DST_X       49:42
`define MSG_DST_Y       41:34
`define MSG_DST_FBITS   33:30
`define MSG_LENGTH      29:22
`define MSG_TYPE        21:14
`define MSG_MSHRID      13:6
`define MSG_OPTIONS     5:0

// header 2
`define MSG_ADDR        63:24
`define MSG_DATA_SIZE   23:21
`define MSG_MASK        7:0

// header 3, source coordinates sit where the destination ones do in header 1
`define MSG_SRC_CHIPID  63:50
`define MSG_SRC_X       49:42
`define MSG_SRC_Y       41:34
`define MSG_SRC_FBITS   33:30

`define MSG_LOAD_REQ    8'd14
`define MSG_STORE_REQ   8'd15
`define MSG_LOAD_RESP   8'd24
`define MSG_STORE_ACK   8'd25
`define MSG_SIZE_8B     3'b100
`define AXI_RESP_OKAY   2'b00

`endif

//--- logic/axil_noc_pkg.sv
// shared request-kind and response-flit types of the axi-lite noc bridge
`include "axil_noc_defines.svh"

package axil_noc_pkg;

    typedef enum logic [1:0] {
        kind_inval = 2'd0,
        kind_load  = 2'd1,
        kind_store = 2'd2
    } req_kind_t;

    // same field order as request header 1
    typedef struct packed {
        logic [`CHIPID_W-1:0]   chipid;
        logic [`COORD_W-1:0]    xpos;
        logic [`COORD_W-1:0]    ypos;
        logic [`FBITS_W-1:0]    fbits;
        logic [`MSG_LEN_W-1:0]  length;     // payload flits after this header
        logic [`MSG_TYPE_W-1:0] msg_type;
        logic [`MSHRID_W-1:0]   mshrid;
        logic [`OPTIONS_W-1:0]  options;
    } resp_hdr_t;

    // a response word is either a header or a raw payload word
    typedef union packed {
        resp_hdr_t              hdr;
        logic [`NOC_DATA_W-1:0] data;
    } resp_flit_t;

endpackage

//--- logic/req_fifo.sv
// synchronous first-word-fall-through queue with full and empty flags
`timescale 1ns/1ps

module req_fifo #(
    parameter int width = 8,
    parameter int depth = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [width-1:0] wr_data,
    input  logic             rd_en,
    output logic [width-1:0] rd_data,
    output logic             full,
    output logic             empty
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    assign full    = (count == cnt_w'(depth));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];   // head shows without a read

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push and pop together
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
        else $error("req_fifo: write while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty)
        else $error("req_fifo: read while empty");

endmodule

//--- logic/axil_req_intake.sv
// axi-lite request intake, ready logic, read capture buffer and the request queues
`timescale 1ns/1ps
`include "axil_noc_defines.svh"

module axil_req_intake (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    input  logic [`AXIL_STRB_W-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output axil_noc_pkg::req_kind_t head_kind,
    output logic [`AXIL_ADDR_W-1:0] head_awaddr,
    output logic [`AXIL_DATA_W-1:0] head_wdata,
    output logic [`AXIL_STRB_W-1:0] head_wstrb,
    output logic [`AXIL_ADDR_W-1:0] head_araddr,
    output logic                    pkt_ready,
    input  logic                    store_done,
    input  logic                    load_done
);
    axil_noc_pkg::req_kind_t kind_wdata;
    logic [1:0] kind_head;
    logic       kind_wr;
    logic       kind_full;
    logic       kind_empty;
    logic       aw_full;
    logic       aw_empty;
    logic       wd_full;
    logic       wd_empty;
    logic       ws_full;
    logic       ws_empty;
    logic       ar_full;
    logic       ar_empty;
    logic       aw_fire;
    logic       w_fire;
    logic       ar_fire;
    logic       rd_buf_full;    // load held back one cycle behind a same-cycle store

    assign awready = !aw_full && !kind_full && !rd_buf_full;
    assign wready  = !wd_full && !ws_full && !kind_full;
    assign arready = !ar_full && !kind_full && !rd_buf_full;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;

    // store goes first, a buffered load follows
    assign kind_wr    = (aw_fire || ar_fire || rd_buf_full) && !kind_full;
    assign kind_wdata = aw_fire ? axil_noc_pkg::kind_store : axil_noc_pkg::kind_load;
    assign head_kind  = axil_noc_pkg::req_kind_t'(kind_head);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_buf_full <= 1'b0;
        end else if (aw_fire && ar_fire) begin
            rd_buf_full <= 1'b1;
        end else if (kind_wr) begin
            rd_buf_full <= 1'b0;
        end
    end

    always_comb begin
        case (head_kind)
            axil_noc_pkg::kind_store: pkt_ready = !kind_empty && !aw_empty && !wd_empty && !ws_empty;
            axil_noc_pkg::kind_load:  pkt_ready = !kind_empty && !ar_empty;
            default:                  pkt_ready = 1'b0;
        endcase
    end

    req_fifo #(.width(2), .depth(`REQ_FIFO_DEPTH)) kind_q (
        .clk(clk), .rst_n(rst_n), .wr_en(kind_wr), .wr_data(kind_wdata),
        .rd_en(store_done || load_done), .rd_data(kind_head), .full(kind_full), .empty(kind_empty)
    );
    req_fifo #(.width(`AXIL_ADDR_W), .depth(`REQ_FIFO_DEPTH)) awaddr_q (
        .clk(clk), .rst_n(rst_n), .wr_en(aw_fire), .wr_data(awaddr),
        .rd_en(store_done), .rd_data(head_awaddr), .full(aw_full), .empty(aw_empty)
    );
    req_fifo #(.width(`AXIL_DATA_W), .depth(`REQ_FIFO_DEPTH)) wdata_q (
        .clk(clk), .rst_n(rst_n), .wr_en(w_fire), .wr_data(wdata),
        .rd_en(store_done), .rd_data(head_wdata), .full(wd_full), .empty(wd_empty)
    );
    req_fifo #(.width(`AXIL_STRB_W), .depth(`REQ_FIFO_DEPTH)) wstrb_q (
        .clk(clk), .rst_n(rst_n), .wr_en(w_fire), .wr_data(wstrb),
        .rd_en(store_done), .rd_data(head_wstrb), .full(ws_full), .empty(ws_empty)
    );
    req_fifo #(.width(`AXIL_ADDR_W), .depth(`REQ_FIFO_DEPTH)) araddr_q (
        .clk(clk), .rst_n(rst_n), .wr_en(ar_fire), .wr_data(araddr),
        .rd_en(load_done), .rd_data(head_araddr), .full(ar_full), .empty(ar_empty)
    );

    // the sender may only retire a request whose parts are all queued
    a_done_needs_pkt: assert property (@(posedge clk) disable iff (!rst_n)
        (store_done || load_done) |-> pkt_ready)
        else $error("axil_req_intake: done strobe without a complete request");

endmodule

//--- logic/noc_flit_sender.sv
// request FSM that formats header and data flits for one queued request at a time
`timescale 1ns/1ps
`include "axil_noc_defines.svh"

module noc_flit_sender (
    input  logic                    clk,
    input  logic                    rst_n,
    input  axil_noc_pkg::req_kind_t head_kind,
    input  logic [`AXIL_ADDR_W-1:0] head_awaddr,
    input  logic [`AXIL_DATA_W-1:0] head_wdata,
    input  logic [`AXIL_STRB_W-1:0] head_wstrb,
    input  logic [`AXIL_ADDR_W-1:0] head_araddr,
    input  logic                    pkt_ready,
    output logic                    store_done,
    output logic                    load_done,
    input  logic [`CHIPID_W-1:0]    dest_chipid,
    input  logic [`COORD_W-1:0]     dest_xpos,
    input  logic [`COORD_W-1:0]     dest_ypos,
    input  logic [`FBITS_W-1:0]     dest_fbits,
    input  logic [`CHIPID_W-1:0]    src_chipid,
    input  logic [`COORD_W-1:0]     src_xpos,
    input  logic [`COORD_W-1:0]     src_ypos,
    input  logic [`FBITS_W-1:0]     src_fbits,
    output logic                    noc_valid_out,
    output logic [`NOC_DATA_W-1:0]  noc_data_out,
    input  logic                    noc_ready_in
);
    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_data
    } state_t;

    state_t                  state;
    logic [1:0]              flit_cnt;  // header 1..3 as 0..2
    logic                    is_store;
    logic                    last_hdr;
    logic [`AXIL_STRB_W-1:0] mask_rev;
    logic [`AXIL_DATA_W-1:0] data_rev;

    assign is_store = (head_kind == axil_noc_pkg::kind_store);
    assign last_hdr = (state == st_header) && (flit_cnt == 2'd2) && noc_ready_in;

    assign load_done     = last_hdr && (head_kind == axil_noc_pkg::kind_load);
    assign store_done    = (state == st_data) && noc_ready_in;
    assign noc_valid_out = (state != st_idle);

    assign mask_rev = {<<{head_wstrb}};     // strobe bit 0 lands in mask bit 7
    assign data_rev = {<<8{head_wdata}};    // big-endian byte order on the noc

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            flit_cnt <= 2'd0;
        end else begin
            case (state)
                st_idle: begin
                    flit_cnt <= 2'd0;
                    if (pkt_ready) begin
                        state <= st_header;
                    end
                end
                st_header: begin
                    if (last_hdr) begin
                        state    <= is_store ? st_data : st_idle;
                        flit_cnt <= 2'd0;
                    end else if (noc_ready_in) begin
                        flit_cnt <= flit_cnt + 2'd1;
                    end
                end
                st_data: begin
                    if (noc_ready_in) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        noc_data_out = '0;
        if (state == st_header) begin
            case (flit_cnt)
                2'd0: begin
                    noc_data_out[`MSG_DST_CHIPID] = dest_chipid;
                    noc_data_out[`MSG_DST_X]      = dest_xpos;
                    noc_data_out[`MSG_DST_Y]      = dest_ypos;
                    noc_data_out[`MSG_DST_FBITS]  = dest_fbits;
                    noc_data_out[`MSG_LENGTH]     = is_store ? 8'd3 : 8'd2;
                    noc_data_out[`MSG_TYPE]       = is_store ? `MSG_STORE_REQ : `MSG_LOAD_REQ;
                    noc_data_out[`MSG_MSHRID]     = '0;
                    noc_data_out[`MSG_OPTIONS]    = '0;
                end
                2'd1: begin
                    noc_data_out[`MSG_ADDR]      = is_store ? head_awaddr : head_araddr;
                    noc_data_out[`MSG_DATA_SIZE] = `MSG_SIZE_8B;
                    noc_data_out[`MSG_MASK]      = is_store ? mask_rev : '0;
                end
                default: begin
                    noc_data_out[`MSG_SRC_CHIPID] = src_chipid;
                    noc_data_out[`MSG_SRC_X]      = src_xpos;
                    noc_data_out[`MSG_SRC_Y]      = src_ypos;
                    noc_data_out[`MSG_SRC_FBITS]  = src_fbits;
                end
            endcase
        end else if (state == st_data) begin
            noc_data_out = data_rev;
        end
    end

    // flit is held until the network takes it
    a_flit_stable: assert property (@(posedge clk) disable iff (!rst_n)
        noc_valid_out && !noc_ready_in |=> noc_valid_out && $stable(noc_data_out))
        else $error("noc_flit_sender: flit changed under back-pressure");

endmodule

//--- logic/noc_resp_decoder.sv
// noc response decoder, drives the axi-lite b and r channels from ack and data flits
`timescale 1ns/1ps
`include "axil_noc_defines.svh"

module noc_resp_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    noc_valid_in,
    input  logic [`NOC_DATA_W-1:0]  noc_data_in,
    output logic                    noc_ready_out,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready
);
    axil_noc_pkg::resp_flit_t flit_in;
    logic                     flit_acc;
    logic                     load_word;
    logic                     in_load;      // payload flits belong to a load response
    logic [`MSG_LEN_W-1:0]    flits_left;   // zero means the next flit is a header
    logic [`AXIL_DATA_W-1:0]  data_rev;

    assign flit_in       = noc_data_in;
    assign noc_ready_out = !bvalid && !rvalid;  // stall the network while a response waits
    assign flit_acc      = noc_valid_in && noc_ready_out;
    assign load_word     = flit_acc && in_load && (flits_left == 8'd1);
    assign data_rev      = {<<8{flit_in.data}};
    assign rresp         = `AXI_RESP_OKAY;
    assign bresp         = `AXI_RESP_OKAY;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flits_left <= '0;
            in_load    <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (flit_acc && flits_left == '0) begin
                flits_left <= flit_in.hdr.length;
                in_load    <= (flit_in.hdr.msg_type == `MSG_LOAD_RESP);
                if (flit_in.hdr.msg_type == `MSG_STORE_ACK) begin
                    bvalid <= 1'b1;
                end
            end else if (flit_acc) begin
                flits_left <= flits_left - 8'd1;
                rvalid     <= load_word ? 1'b1 : rvalid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_word) begin
            rdata <= data_rev;
        end
    end

    a_one_resp: assert property (@(posedge clk) disable iff (!rst_n) !(rvalid && bvalid))
        else $error("noc_resp_decoder: b and r responses pending together");

endmodule

//--- logic/axil_noc_bridge.sv
// axi-lite to noc bridge top level, joins request intake, flit sender and response decoder
`timescale 1ns/1ps
`include "axil_noc_defines.svh"

module axil_noc_bridge (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    input  logic [`AXIL_STRB_W-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    output logic                    noc_valid_out,
    output logic [`NOC_DATA_W-1:0]  noc_data_out,
    input  logic                    noc_ready_in,
    input  logic                    noc_valid_in,
    input  logic [`NOC_DATA_W-1:0]  noc_data_in,
    output logic                    noc_ready_out,
    input  logic [`CHIPID_W-1:0]    dest_chipid,
    input  logic [`COORD_W-1:0]     dest_xpos,
    input  logic [`COORD_W-1:0]     dest_ypos,
    input  logic [`FBITS_W-1:0]     dest_fbits,
    input  logic [`CHIPID_W-1:0]    src_chipid,
    input  logic [`COORD_W-1:0]     src_xpos,
    input  logic [`COORD_W-1:0]     src_ypos,
    input  logic [`FBITS_W-1:0]     src_fbits
);
    // queue heads and pop strobes between intake and sender
    axil_noc_pkg::req_kind_t head_kind;
    logic [`AXIL_ADDR_W-1:0] head_awaddr;
    logic [`AXIL_DATA_W-1:0] head_wdata;
    logic [`AXIL_STRB_W-1:0] head_wstrb;
    logic [`AXIL_ADDR_W-1:0] head_araddr;
    logic                    pkt_ready;
    logic                    store_done;
    logic                    load_done;

    axil_req_intake u_intake (.*);

    noc_flit_sender u_sender (.*);

    noc_resp_decoder u_resp (.*);   // response path is independent of the request queues

endmodule

//--- sim/noc_target_model.sv
// noc memory target that checks request flits and answers with acks and load data
`timescale 1ns/1ps
`include "axil_noc_defines.svh"

module noc_target_model (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    input  logic                    awready,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    input  logic [`AXIL_STRB_W-1:0] wstrb,
    input  logic                    wvalid,
    input  logic                    wready,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    input  logic                    arready,
    input  logic                    noc_valid_out,
    input  logic [`NOC_DATA_W-1:0]  noc_data_out,
    output logic                    noc_ready_in,
    output logic                    noc_valid_in,
    output logic [`NOC_DATA_W-1:0]  noc_data_in,
    input  logic                    noc_ready_out,
    input  logic [`CHIPID_W-1:0]    dest_chipid,
    input  logic [`COORD_W-1:0]     dest_xpos,
    input  logic [`COORD_W-1:0]     dest_ypos,
    input  logic [`FBITS_W-1:0]     dest_fbits,
    input  logic [`CHIPID_W-1:0]    src_chipid,
    input  logic [`COORD_W-1:0]     src_xpos,
    input  logic [`COORD_W-1:0]     src_ypos,
    input  logic [`FBITS_W-1:0]     src_fbits,
    output logic                    model_error
);
    logic [`NOC_DATA_W-1:0]  mem [256];
    logic [`AXIL_ADDR_W-1:0] st_addr_q [$];   // expected requests, snooped from the axi side
    logic [`AXIL_DATA_W-1:0] st_data_q [$];
    logic [`AXIL_STRB_W-1:0] st_strb_q [$];
    logic [`AXIL_ADDR_W-1:0] ld_addr_q [$];
    logic [`NOC_DATA_W-1:0]  resp_q [$];
    logic [1:0]              flit_idx;        // position inside the current packet
    logic                    pkt_store;
    logic [7:0]              word_idx;
    logic [7:0]              pkt_mask;

    function automatic logic [7:0] bit_rev8(input logic [7:0] s);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[7 - i] = s[i];
        end
        return r;
    endfunction

    function automatic logic [63:0] byte_rev64(input logic [63:0] d);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[63 - 8 * i -: 8] = d[8 * i +: 8];
        end
        return r;
    endfunction

    task automatic flag_error(input string msg);
        $display("ERROR @ %0t: target model, %s", $time, msg);
        model_error = 1'b1;
    endtask

    task automatic take_flit(input logic [`NOC_DATA_W-1:0] f);
        axil_noc_pkg::resp_flit_t rsp;
        logic [`AXIL_ADDR_W-1:0]  addr;
        rsp = '0;
        rsp.hdr.chipid = src_chipid;    // answers go back to the requester
        rsp.hdr.xpos   = src_xpos;
        rsp.hdr.ypos   = src_ypos;
        rsp.hdr.fbits  = src_fbits;
        case (flit_idx)
            2'd0: begin
                pkt_store = (f[`MSG_TYPE] == `MSG_STORE_REQ);
                assert (pkt_store || f[`MSG_TYPE] == `MSG_LOAD_REQ)
                    else flag_error("unknown request type");
                assert (f[`MSG_LENGTH] == (pkt_store ? 8'd3 : 8'd2))
                    else flag_error("wrong packet length");
                assert (f[`MSG_DST_CHIPID] == dest_chipid && f[`MSG_DST_X] == dest_xpos &&
                        f[`MSG_DST_Y] == dest_ypos && f[`MSG_DST_FBITS] == dest_fbits)
                    else flag_error("wrong destination fields");
                flit_idx = 2'd1;
            end
            2'd1: begin
                addr     = f[`MSG_ADDR];
                word_idx = addr[10:3];
                pkt_mask = f[`MSG_MASK];
                assert (f[`MSG_DATA_SIZE] == `MSG_SIZE_8B) else flag_error("wrong data size");
                if (pkt_store) begin
                    assert (addr == st_addr_q[0]) else flag_error("store address mismatch");
                    assert (pkt_mask == bit_rev8(st_strb_q[0]))
                        else flag_error("mask is not the bit-reversed strobe");
                end else begin
                    assert (addr == ld_addr_q[0]) else flag_error("load address mismatch");
                    assert (pkt_mask == 8'h00) else flag_error("load mask is not zero");
                end
                flit_idx = 2'd2;
            end
            2'd2: begin
                assert (f[`MSG_SRC_CHIPID] == src_chipid && f[`MSG_SRC_X] == src_xpos &&
                        f[`MSG_SRC_Y] == src_ypos && f[`MSG_SRC_FBITS] == src_fbits)
                    else flag_error("wrong source fields");
                if (pkt_store) begin
                    flit_idx = 2'd3;
                end else begin
                    rsp.hdr.length   = 8'd1;
                    rsp.hdr.msg_type = `MSG_LOAD_RESP;
                    resp_q.push_back(rsp.data);
                    rsp.data = mem[word_idx];
                    resp_q.push_back(rsp.data);
                    void'(ld_addr_q.pop_front());
                    flit_idx = 2'd0;
                end
            end
            default: begin
                assert (f == byte_rev64(st_data_q[0])) else flag_error("data flit mismatch");
                for (int i = 0; i < 8; i++) begin
                    if (pkt_mask[i]) begin
                        mem[word_idx][8 * i +: 8] = f[8 * i +: 8];  // mask bit i covers flit byte i
                    end
                end
                rsp.hdr.length   = 8'd0;
                rsp.hdr.msg_type = `MSG_STORE_ACK;
                resp_q.push_back(rsp.data);
                void'(st_addr_q.pop_front());
                void'(st_data_q.pop_front());
                void'(st_strb_q.pop_front());
                flit_idx = 2'd0;
            end
        endcase
    endtask

    // request side, snoops axi handshakes and takes flits under random back-pressure
    initial begin
        logic                   take;
        logic [`NOC_DATA_W-1:0] flit;
        model_error  = 1'b0;
        flit_idx     = 2'd0;
        pkt_store    = 1'b0;
        noc_ready_in = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8{8'(i)}} ^ 64'h0f1e_2d3c_4b5a_6978;
        end
        forever begin
            @(negedge clk);
            take = noc_valid_out && noc_ready_in;
            flit = noc_data_out;
            if (awvalid && awready) st_addr_q.push_back(awaddr);
            if (wvalid && wready) begin
                st_data_q.push_back(wdata);
                st_strb_q.push_back(wstrb);
            end
            if (arvalid && arready) ld_addr_q.push_back(araddr);
            @(posedge clk);
            #2;
            noc_ready_in = ($urandom_range(3) != 0);
            if (take) take_flit(flit);
        end
    end

    // response side, one flit per cycle while the bridge takes them
    initial begin
        logic sent;
        noc_valid_in = 1'b0;
        noc_data_in  = '0;
        forever begin
            @(negedge clk);
            sent = noc_valid_in && noc_ready_out;
            @(posedge clk);
            #3;
            if (sent) void'(resp_q.pop_front());
            noc_valid_in = (resp_q.size() != 0);
            noc_data_in  = (resp_q.size() != 0) ? resp_q[0] : '0;
        end
    end

endmodule

//--- sim/tb_axil_noc_bridge.sv
// testbench for the axi-lite to noc bridge with axi stimulus and end-to-end checks
`timescale 1ns/1ps
`include "axil_noc_defines.svh"

module tb_axil_noc_bridge;
    localparam int     n_rounds     = 25;
    localparam int     round_budget = 400;  // cycles allowed per round
    localparam int     clk_period   = 20;
    localparam longint watchdog_ns  = n_rounds * round_budget * clk_period;

    logic                    clk;
    logic                    rst_n;
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic [`AXIL_STRB_W-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [`AXIL_DATA_W-1:0] rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic                    noc_valid_out;
    logic [`NOC_DATA_W-1:0]  noc_data_out;
    logic                    noc_ready_in;
    logic                    noc_valid_in;
    logic [`NOC_DATA_W-1:0]  noc_data_in;
    logic                    noc_ready_out;
    logic [`CHIPID_W-1:0]    dest_chipid;
    logic [`COORD_W-1:0]     dest_xpos;
    logic [`COORD_W-1:0]     dest_ypos;
    logic [`FBITS_W-1:0]     dest_fbits;
    logic [`CHIPID_W-1:0]    src_chipid;
    logic [`COORD_W-1:0]     src_xpos;
    logic [`COORD_W-1:0]     src_ypos;
    logic [`FBITS_W-1:0]     src_fbits;
    logic                    model_error;
    logic [`AXIL_DATA_W-1:0] exp_rdata [$];
    int                      b_expected = 0;
    int                      b_seen = 0;

    assign dest_chipid = 14'h0012;
    assign dest_xpos   = 8'd3;
    assign dest_ypos   = 8'd5;
    assign dest_fbits  = 4'ha;
    assign src_chipid  = 14'h0007;
    assign src_xpos    = 8'd1;
    assign src_ypos    = 8'd2;
    assign src_fbits   = 4'h0;

    axil_noc_bridge uut (.*);

    noc_target_model u_target (.*);

    task automatic stop_on_error(input string msg);
        $display("ERROR @ %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // applies an axi write strobe to a stored word
    function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                                input logic [63:0] new_w,
                                                input logic [7:0]  strb);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8 * i +: 8] = strb[i] ? new_w[8 * i +: 8] : old_w[8 * i +: 8];
        end
        return r;
    endfunction

    // drives aw/w and ar together and waits for every requested handshake
    task automatic issue(input logic do_wr, input logic do_rd, input logic [39:0] addr,
                         input logic [63:0] data, input logic [7:0] strb);
        logic aw_left;
        logic w_left;
        logic ar_left;
        logic aw_hs;
        logic w_hs;
        logic ar_hs;
        aw_left = do_wr;
        w_left  = do_wr;
        ar_left = do_rd;
        awaddr  = addr;
        araddr  = addr;
        wdata   = data;
        wstrb   = strb;
        if (do_wr) b_expected++;
        while (aw_left || w_left || ar_left) begin
            awvalid = aw_left;
            wvalid  = w_left;
            arvalid = ar_left;
            @(negedge clk);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            ar_hs = arvalid && arready;
            @(posedge clk);
            #2;
            aw_left = aw_left && !aw_hs;
            w_left  = w_left && !w_hs;
            ar_left = ar_left && !ar_hs;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns without finishing the test", watchdog_ns);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    // b and r acceptance with random stalls
    initial begin
        rready = 1'b0;
        bready = 1'b0;
        forever begin
            @(negedge clk);
            if (rvalid && rready) begin
                assert (exp_rdata.size() != 0) else stop_on_error("read response with none pending");
                assert (rdata == exp_rdata[0] && rresp == `AXI_RESP_OKAY)
                    else stop_on_error($sformatf("rdata %h rresp %0d, expected %h OKAY",
                                                 rdata, rresp, exp_rdata[0]));
                void'(exp_rdata.pop_front());
            end
            if (bvalid && bready) begin
                assert (bresp == `AXI_RESP_OKAY) else stop_on_error("bresp is not OKAY");
                b_seen++;
            end
            @(posedge clk);
            #2;
            rready = ($urandom_range(3) != 0);
            bready = ($urandom_range(3) != 0);
        end
    end

    a_flit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        noc_valid_out && !noc_ready_in |=> noc_valid_out && $stable(noc_data_out))
        else stop_on_error("request flit changed under back-pressure");
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else stop_on_error("r channel changed before its handshake");
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else stop_on_error("b channel changed before its handshake");
    a_resp_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid || bvalid) |-> !noc_ready_out)
        else stop_on_error("noc_ready_out high while a response waits");
    a_capture_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && awready && arvalid && arready |=> !awready && !arready)
        else stop_on_error("aw or ar ready in the cycle after a same-cycle aw and ar");
    a_model_clean: assert property (@(posedge clk) !model_error)
        else stop_on_error("target model found a bad request flit");

    initial begin
        logic [63:0] rnd;
        logic [39:0] addr;
        logic [63:0] d1;
        logic [63:0] d2;
        logic [7:0]  strb;
        void'($urandom(32'he97cfa41));
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        assert (!noc_valid_out && !bvalid && !rvalid)
            else stop_on_error("valid outputs high during reset");
        assert (awready && wready && arready && noc_ready_out)
            else stop_on_error("ready outputs low with all queues empty");
        rst_n = 1'b1;
        for (int r = 0; r < n_rounds; r++) begin
            rnd  = {$urandom(), $urandom()};
            addr = {rnd[39:3], 3'b000};
            d1   = {$urandom(), $urandom()};
            d2   = {$urandom(), $urandom()};
            strb = 8'($urandom_range(255));
            issue(1'b1, 1'b0, addr, d1, 8'hff);
            exp_rdata.push_back(merge_bytes(d1, d2, strb));
            if (r % 2 == 0) begin
                issue(1'b1, 1'b0, addr, d2, strb);
                issue(1'b0, 1'b1, addr, '0, '0);
            end else begin
                issue(1'b1, 1'b1, addr, d2, strb);  // read in the same cycle sees the new data
            end
        end
        while (exp_rdata.size() != 0 || b_seen != b_expected) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
logic/axil_noc_pkg.sv
logic/req_fifo.sv
logic/axil_req_intake.sv
logic/noc_flit_sender.sv
logic/noc_resp_decoder.sv
logic/axil_noc_bridge.sv
sim/noc_target_model.sv
sim/tb_axil_noc_bridge.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_axil_noc_bridge
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
